/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_ps2_keyboard
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/kbd_ctrl_fsm.sv */
// Keyboard receive and hold control
`timescale 1ns/10ps

module kbd_ctrl_fsm
(
	input  logic clk,
	input  logic reset,
	input  logic key_strobe,	// new key event to host
	input  logic key_ack,	// host took the key
	input  logic hold_timeout,	// host too slow
	output logic timer_clear,
	output logic ps2_clk_low	// inhibit keyboard clock
);

	typedef enum logic
	{
		ST_RECV,	// clock released, waiting for a key
		ST_HOLD	// clock inhibited, waiting for host
	} state_t;

	state_t state_q;
	state_t state_d;

	// --------------------------------------------------
	// state register and next state
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			state_q <= ST_RECV;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_RECV:
				if (key_strobe)
					state_d = ST_HOLD;	// stall keyboard until host acks
			ST_HOLD:
				if (key_ack || hold_timeout)
					state_d = ST_RECV;
			default:
				state_d = ST_RECV;
		endcase
	end

	assign timer_clear = (state_q == ST_RECV);	// timer runs in hold only
	assign ps2_clk_low = (state_q == ST_HOLD);

endmodule

/* design/kbd_hold_timer.sv */
// Keyboard hold timer
`timescale 1ns/10ps

module kbd_hold_timer
#(
	parameter int HOLD_TIMEOUT_BITS = 20	// timeout after 2**N cycles
)
(
	input  logic clk,
	input  logic reset,
	input  logic timer_clear,	// hold count at zero
	output logic hold_timeout	// stays high once saturated
);

	logic [HOLD_TIMEOUT_BITS:0] count;	// top bit is the timeout flag

	always_ff @(posedge clk)
	begin
		if (reset || timer_clear)
			count <= '0;
		else if (!count[HOLD_TIMEOUT_BITS])
			count <= count + 1'b1;	// stop at saturation
	end

	assign hold_timeout = count[HOLD_TIMEOUT_BITS];

endmodule

/* design/key_event_filter.sv */
// Typematic filter and reset chord
`timescale 1ns/10ps

module key_event_filter
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   map_valid,	// translated key present
	input  ps2kbd_pkg::amiga_key_t akey,
	input  logic                   is_ctrl,
	input  logic                   is_lalt,
	input  logic                   is_ralt,
	output logic                   key_strobe,	// new key event
	output ps2kbd_pkg::amiga_key_t key_code,	// valid with key_strobe
	output logic                   kbd_reset	// ctrl and both alts held
);

	ps2kbd_pkg::amiga_key_t last_key;	// last key pressed
	ps2kbd_pkg::key_num_t   new_num;
	ps2kbd_pkg::key_num_t   last_num;
	logic                   new_rel;	// incoming event is a release
	logic                   same_num;
	logic                   duplicate;	// typematic repeat
	logic                   rel_ctrl;	// control is up
	logic                   rel_lalt;	// left alt is up
	logic                   rel_ralt;	// right alt is up

	// --------------------------------------------------
	// duplicate filter
	// --------------------------------------------------
	assign new_num   = akey[6:0];
	assign new_rel   = akey[7];
	assign last_num  = last_key[6:0];
	assign same_num  = (new_num == last_num);
	assign duplicate = same_num && (new_rel == last_key[7]);

	always_ff @(posedge clk)
	begin
		if (reset)
			last_key <= '0;
		else if (map_valid && (!new_rel || same_num))
			last_key <= akey;	// any press, or release of latched key
	end

	assign key_strobe = map_valid && !duplicate;
	assign key_code   = akey;

	// --------------------------------------------------
	// reset chord
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rel_ctrl <= 1'b1;	// all keys up
			rel_lalt <= 1'b1;
			rel_ralt <= 1'b1;
		end
		else if (map_valid)
		begin
			if (is_ctrl)
				rel_ctrl <= new_rel;
			if (is_lalt)
				rel_lalt <= new_rel;
			if (is_ralt)
				rel_ralt <= new_rel;
		end
	end

	assign kbd_reset = ~(rel_ctrl | rel_lalt | rel_ralt);	// all three down

endmodule

/* design/ps2_keyboard.sv */
// PS/2 keyboard front end
`timescale 1ns/10ps

module ps2_keyboard
#(
	parameter int HOLD_TIMEOUT_BITS = 20	// hold lasts at most 2**N cycles
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ps2_clk,	// from keyboard wrapper
	input  logic                   ps2_dat,
	input  logic                   key_ack,	// host acknowledge
	output ps2kbd_pkg::amiga_key_t key_code,	// valid with key_strobe
	output logic                   key_strobe,
	output logic                   kbd_reset,	// reset chord held
	output logic                   ps2_clk_low	// pull keyboard clock low
);

	logic                   frame_done;	// receiver to map
	ps2kbd_pkg::scan_code_t scan_code;
	logic                   map_valid;	// map to filter
	ps2kbd_pkg::amiga_key_t akey;
	logic                   is_ctrl;
	logic                   is_lalt;
	logic                   is_ralt;
	logic                   timer_clear;	// fsm and timer
	logic                   hold_timeout;

	// --------------------------------------------------
	// receive path
	// --------------------------------------------------
	ps2_rx_shifter i_rx (.clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_dat(ps2_dat),
		.frame_done(frame_done), .scan_code(scan_code));

	scancode_map i_map (.clk(clk), .reset(reset), .frame_done(frame_done),
		.scan_code(scan_code), .map_valid(map_valid), .akey(akey),
		.is_ctrl(is_ctrl), .is_lalt(is_lalt), .is_ralt(is_ralt));

	key_event_filter i_filter (.clk(clk), .reset(reset), .map_valid(map_valid), .akey(akey),
		.is_ctrl(is_ctrl), .is_lalt(is_lalt), .is_ralt(is_ralt),
		.key_strobe(key_strobe), .key_code(key_code), .kbd_reset(kbd_reset));

	// --------------------------------------------------
	// hold control
	// --------------------------------------------------
	kbd_hold_timer #(.HOLD_TIMEOUT_BITS(HOLD_TIMEOUT_BITS)) i_timer (.clk(clk),
		.reset(reset), .timer_clear(timer_clear), .hold_timeout(hold_timeout));

	kbd_ctrl_fsm i_fsm (.clk(clk), .reset(reset), .key_strobe(key_strobe), .key_ack(key_ack),
		.hold_timeout(hold_timeout), .timer_clear(timer_clear), .ps2_clk_low(ps2_clk_low));

endmodule

/* design/ps2_rx_shifter.sv */
// PS/2 frame receiver
`timescale 1ns/10ps

module ps2_rx_shifter
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   ps2_clk,	// keyboard clock line
	input  logic                   ps2_dat,	// keyboard data line
	output logic                   frame_done,	// one cycle per complete frame
	output ps2kbd_pkg::scan_code_t scan_code	// data byte, valid with frame_done
);

	logic [1:0] clk_sync;	// clock line stages, [0] newest
	logic [1:0] dat_sync;	// data line stages, [0] newest
	logic       clk_fall;	// synchronized falling clock edge

	// ones mark an idle shifter, the start bit walks down to bit 0
	logic [ps2kbd_pkg::PS2_FRAME_BITS-1:0] rx_shift;

	// --------------------------------------------------
	// line synchronizers
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		clk_sync <= {clk_sync[0], ps2_clk};	// shift in new sample
		dat_sync <= {dat_sync[0], ps2_dat};
	end

	assign clk_fall = clk_sync[1] & ~clk_sync[0];	// was high, now low

	// --------------------------------------------------
	// frame shifter
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset || frame_done)
			rx_shift <= '1;	// back to idle, ready for next frame
		else if (clk_fall)
			rx_shift <= {dat_sync[1], rx_shift[ps2kbd_pkg::PS2_FRAME_BITS-1:1]};	// lsb first
	end

	// data bit taken from last sample before the clock fell
	assign frame_done = ~rx_shift[0];	// start bit at the bottom
	assign scan_code  = rx_shift[8:1];	// data byte above start bit

	// parity and stop bits pass through unchecked

endmodule

/* design/ps2kbd_pkg.sv */
// PS/2 keyboard shared definitions
package ps2kbd_pkg;

	// --------------------------------------------------
	// code types
	// --------------------------------------------------
	typedef logic [7:0]  scan_code_t;	// one raw PS/2 byte
	typedef logic [7:0]  amiga_key_t;	// bit 7 release, 6:0 key number
	typedef logic [6:0]  key_num_t;	// key number without release flag
	typedef logic [15:0] map_entry_t;	// one translation table word

	// --------------------------------------------------
	// translation table fields
	// --------------------------------------------------
	localparam int MAP_VALID_BIT  = 15;	// entry is a real amiga key
	localparam int MAP_CTRL_BIT   = 14;	// control key
	localparam int MAP_LALT_BIT   = 13;	// left alt key
	localparam int MAP_RALT_BIT   = 12;	// right alt key
	localparam int MAP_PREFIX_BIT = 7;	// entry is a PS/2 prefix code
	localparam int MAP_EXT_BIT    = 0;	// with prefix bit, extended prefix
	localparam int MAP_REL_BIT    = 1;	// with prefix bit, release prefix

	// bits 6:0 of a key entry carry the amiga key number

	// --------------------------------------------------
	// PS/2 framing
	// --------------------------------------------------
	localparam int PS2_FRAME_BITS = 11;	// start, 8 data, parity, stop

	localparam scan_code_t EXT_PREFIX = 8'hE0;	// extended key follows
	localparam scan_code_t REL_PREFIX = 8'hF0;	// key release follows

endpackage

/* design/scancode_map.sv */
// PS/2 to Amiga key translation
`timescale 1ns/10ps

module scancode_map
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   frame_done,	// new scan code present
	input  ps2kbd_pkg::scan_code_t scan_code,
	output logic                   map_valid,	// one cycle, real key only
	output ps2kbd_pkg::amiga_key_t akey,	// release flag and key number
	output logic                   is_ctrl,
	output logic                   is_lalt,
	output logic                   is_ralt
);

	ps2kbd_pkg::map_entry_t table_q;	// registered table word
	ps2kbd_pkg::key_num_t   key_num;	// key number field of table_q
	logic                   lookup_d;	// table_q holds a fresh lookup
	logic                   ext_flag;	// E0 seen
	logic                   rel_flag;	// F0 seen
	logic                   is_prefix;

	// --------------------------------------------------
	// prefix tracking
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lookup_d <= 1'b0;
			ext_flag <= 1'b0;
			rel_flag <= 1'b0;
		end
		else
		begin
			lookup_d <= frame_done;	// table read takes one cycle
			if (lookup_d && is_prefix && table_q[ps2kbd_pkg::MAP_EXT_BIT])
				ext_flag <= 1'b1;	// extended key next
			else if (lookup_d && is_prefix && table_q[ps2kbd_pkg::MAP_REL_BIT])
				rel_flag <= 1'b1;	// release of next key
			else if (lookup_d)
			begin
				ext_flag <= 1'b0;	// any other code ends the sequence
				rel_flag <= 1'b0;
			end
		end
	end

	assign is_prefix = table_q[ps2kbd_pkg::MAP_PREFIX_BIT];
	assign key_num   = table_q[6:0];
	assign map_valid = table_q[ps2kbd_pkg::MAP_VALID_BIT] & lookup_d;
	assign akey      = {rel_flag, key_num};	// flag from before this code
	assign is_ctrl   = table_q[ps2kbd_pkg::MAP_CTRL_BIT];
	assign is_lalt   = table_q[ps2kbd_pkg::MAP_LALT_BIT];
	assign is_ralt   = table_q[ps2kbd_pkg::MAP_RALT_BIT];

	// --------------------------------------------------
	// translation table, address {ext_flag, scan_code}
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (frame_done)
		begin
			case ({ext_flag, scan_code})
				9'h001: table_q <= 16'h8058;	// F9
				9'h003: table_q <= 16'h8054;	// F5
				9'h004: table_q <= 16'h8052;	// F3
				9'h005: table_q <= 16'h8050;	// F1
				9'h006: table_q <= 16'h8051;	// F2
				9'h009: table_q <= 16'h8059;	// F10
				9'h00a: table_q <= 16'h8057;	// F8
				9'h00b: table_q <= 16'h8055;	// F6
				9'h00c: table_q <= 16'h8053;	// F4
				9'h011: table_q <= 16'ha064;	// left alt
				9'h012: table_q <= 16'h8060;	// left shift
				9'h014: table_q <= 16'hc063;	// control
				9'h015: table_q <= 16'h8010;	// q
				9'h016: table_q <= 16'h8001;	// 1
				9'h01a: table_q <= 16'h8031;	// z
				9'h01b: table_q <= 16'h8021;	// s
				9'h01c: table_q <= 16'h8020;	// a
				9'h01d: table_q <= 16'h8011;	// w
				9'h01e: table_q <= 16'h8002;	// 2
				9'h021: table_q <= 16'h8033;	// c
				9'h022: table_q <= 16'h8032;	// x
				9'h023: table_q <= 16'h8022;	// d
				9'h024: table_q <= 16'h8012;	// e
				9'h025: table_q <= 16'h8004;	// 4
				9'h026: table_q <= 16'h8003;	// 3
				9'h029: table_q <= 16'h8040;	// space
				9'h02a: table_q <= 16'h8034;	// v
				9'h02b: table_q <= 16'h8023;	// f
				9'h02c: table_q <= 16'h8014;	// t
				9'h02d: table_q <= 16'h8013;	// r
				9'h02e: table_q <= 16'h8005;	// 5
				9'h031: table_q <= 16'h8036;	// n
				9'h032: table_q <= 16'h8035;	// b
				9'h033: table_q <= 16'h8025;	// h
				9'h034: table_q <= 16'h8024;	// g
				9'h035: table_q <= 16'h8015;	// y
				9'h036: table_q <= 16'h8006;	// 6
				9'h03a: table_q <= 16'h8037;	// m
				9'h03b: table_q <= 16'h8026;	// j
				9'h03c: table_q <= 16'h8016;	// u
				9'h03d: table_q <= 16'h8007;	// 7
				9'h03e: table_q <= 16'h8008;	// 8
				9'h042: table_q <= 16'h8027;	// k
				9'h043: table_q <= 16'h8017;	// i
				9'h044: table_q <= 16'h8018;	// o
				9'h045: table_q <= 16'h800a;	// 0
				9'h046: table_q <= 16'h8009;	// 9
				9'h04b: table_q <= 16'h8028;	// l
				9'h04d: table_q <= 16'h8019;	// p
				9'h059: table_q <= 16'h8061;	// right shift
				9'h05a: table_q <= 16'h8044;	// enter
				9'h083: table_q <= 16'h8056;	// F7
				{1'b0, ps2kbd_pkg::EXT_PREFIX}: table_q <= 16'h0081;
				{1'b0, ps2kbd_pkg::REL_PREFIX}: table_q <= 16'h0082;
				9'h111: table_q <= 16'h9065;	// right alt
				9'h16b: table_q <= 16'h804f;	// arrow left
				9'h172: table_q <= 16'h804d;	// arrow down
				9'h174: table_q <= 16'h804e;	// arrow right
				9'h175: table_q <= 16'h804c;	// arrow up
				{1'b1, ps2kbd_pkg::EXT_PREFIX}: table_q <= 16'h0081;	// repeated E0
				{1'b1, ps2kbd_pkg::REL_PREFIX}: table_q <= 16'h0082;	// extended release
				default: table_q <= 16'h0000;	// no key
			endcase
		end
	end

endmodule

/* sources.f */
design/ps2kbd_pkg.sv
design/ps2_rx_shifter.sv
design/scancode_map.sv
design/key_event_filter.sv
design/kbd_hold_timer.sv
design/kbd_ctrl_fsm.sv
design/ps2_keyboard.sv
verif/kbd_checker.sv
verif/tb_ps2_keyboard.sv

/* verif/kbd_checker.sv */
// Key event checker
`timescale 1ns/10ps

module kbd_checker
#(
	parameter int HOLD_TIMEOUT_BITS = 8,
	parameter int HOLD_MARGIN       = 4	// cycles allowed past the timeout
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   key_strobe,
	input  ps2kbd_pkg::amiga_key_t key_code,
	input  logic                   kbd_reset,
	input  logic                   ps2_clk_low,
	input  logic                   key_ack,
	input  logic                   ack_mode,	// host acknowledges keys
	input  logic                   exp_valid,	// expectation record present
	input  logic                   exp_kind,	// 0 key code, 1 chord level
	input  logic [7:0]             exp_value,
	input  logic                   run_done,	// stimulus finished
	output int                     mismatch_count,
	output int                     fault_count
);

	localparam int HOLD_CYCLES = 2 ** HOLD_TIMEOUT_BITS;

	logic [7:0] exp_keys [$];	// key codes still to come
	logic [7:0] want;
	logic       strobe_d;	// strobe seen last cycle
	logic       ack_d;	// ack seen during hold last cycle
	logic       ack_given;	// ack seen in this hold
	logic       hold_d;	// inhibit level last cycle
	logic       stuck_told;
	logic       end_told;
	int         hold_len;	// cycles of inhibit so far

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
		mismatch_count = mismatch_count + 1;
	endtask

	task automatic report_fault(input string what);
		$display("ERROR at %0t: %s", $time, what);
		fault_count = fault_count + 1;
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			exp_keys.delete();
			mismatch_count = 0;
			fault_count    = 0;
			strobe_d       = 1'b0;
			ack_d          = 1'b0;
			ack_given      = 1'b0;
			hold_d         = 1'b0;
			stuck_told     = 1'b0;
			end_told       = 1'b0;
			hold_len       = 0;
		end
		else
		begin
			// --------------------------------------------------
			// key events and chord level
			// --------------------------------------------------
			if (exp_valid && !exp_kind)
				exp_keys.push_back(exp_value);	// strobe comes later
			if (exp_valid && exp_kind && kbd_reset !== exp_value[0])
				report_mismatch("kbd_reset", {7'd0, exp_value[0]}, {7'd0, kbd_reset});
			if (key_strobe && exp_keys.size() == 0)
				report_fault($sformatf("extra key strobe with code %h", key_code));
			else if (key_strobe)
			begin
				want = exp_keys.pop_front();	// oldest expectation
				if (key_code !== want)
					report_mismatch("key_code", want, key_code);
			end

			// --------------------------------------------------
			// clock inhibit
			// --------------------------------------------------
			if (strobe_d && !ps2_clk_low)
				report_fault("clock inhibit not raised after key strobe");
			if (ps2_clk_low)
			begin
				hold_len = hold_len + 1;
				if (ack_d)
					report_fault("clock inhibit still held after key_ack");
				if (hold_len > HOLD_CYCLES + HOLD_MARGIN && !stuck_told)
				begin
					report_fault("clock inhibit stuck past the hold timeout");
					stuck_told = 1'b1;	// once per hold
				end
			end
			else if (hold_d)
			begin
				// inhibit just released
				if (ack_mode && !ack_given)
					report_fault("clock inhibit released before key_ack");
				if (!ack_mode && hold_len < HOLD_CYCLES)
					report_fault($sformatf("clock inhibit released after %0d cycles", hold_len));
				hold_len   = 0;
				ack_given  = 1'b0;
				stuck_told = 1'b0;
			end
			ack_d     = ps2_clk_low && key_ack;	// fsm leaves hold next cycle
			ack_given = ack_given || ack_d;
			strobe_d  = key_strobe;
			hold_d    = ps2_clk_low;

			if (run_done && !end_told)
			begin
				if (exp_keys.size() != 0)
					report_fault($sformatf("missing key strobe, %0d expected events never came",
						exp_keys.size()));
				end_told = 1'b1;
			end
		end
	end

endmodule

/* verif/ps2_keyboard_golden.txt */
// one record per line: opcode nibble, underscore, argument byte in hex
// 1 send scan byte, 2 ack mode (01 ack, 00 noack), 3 expect key code, 4 expect chord, 0 end
2_01	// host acknowledges each key
3_20	// a press
1_1c
3_a0	// a release
1_f0
1_1c
3_4c	// arrow up, extended
1_e0
1_75
1_0d	// tab, not in table
3_21	// s press, repeat dropped
1_1b
1_1b
3_a1
1_f0
1_1b
3_21	// s again after release
1_1b
3_22	// d between two s presses
1_23
3_21
1_1b
2_00	// host ignores keys
3_40	// space, hold times out
1_29
2_01
3_63	// control
1_14
3_64	// left alt
1_11
4_00	// chord not complete yet
3_65	// right alt, extended
1_e0
1_11
4_01
3_e4	// left alt release
1_f0
1_11
4_00
0_00	// end of records

/* verif/tb_ps2_keyboard.sv */
// PS/2 keyboard testbench
`timescale 1ns/10ps

module tb_ps2_keyboard;

	localparam int HOLD_BITS   = 8;	// short hold timeout
	localparam int HALF_BIT    = 8;	// system cycles per half PS/2 clock
	localparam int IDLE_GAP    = 32;	// cycles after each frame
	localparam int FRAME_COST  = 240;	// cycles per frame, with room
	localparam int HOLD_COST   = 2 ** HOLD_BITS + 16;	// worst hold per key
	localparam int SCRIPT_SIZE = 64;

	logic                   clk;
	logic                   reset;
	logic                   ps2_clk;
	logic                   ps2_dat;
	logic                   key_ack;
	ps2kbd_pkg::amiga_key_t key_code;
	logic                   key_strobe;
	logic                   kbd_reset;
	logic                   ps2_clk_low;

	logic       ack_mode;	// 1 host acks, 0 host ignores
	logic       exp_valid;
	logic       exp_kind;
	logic [7:0] exp_value;
	logic       run_done;
	int         mismatch_count;
	int         fault_count;

	logic [11:0] script [0:SCRIPT_SIZE-1];	// opcode nibble, argument byte
	int          n_records;
	int          n_send;
	int          n_key;
	int          idx;
	int          script_errors;
	int          cycle_count;
	int          timeout_limit;

	ps2_keyboard #(.HOLD_TIMEOUT_BITS(HOLD_BITS)) i_dut (.clk(clk), .reset(reset),
		.ps2_clk(ps2_clk), .ps2_dat(ps2_dat), .key_ack(key_ack), .key_code(key_code),
		.key_strobe(key_strobe), .kbd_reset(kbd_reset), .ps2_clk_low(ps2_clk_low));

	kbd_checker #(.HOLD_TIMEOUT_BITS(HOLD_BITS)) i_chk (.clk(clk), .reset(reset),
		.key_strobe(key_strobe), .key_code(key_code), .kbd_reset(kbd_reset),
		.ps2_clk_low(ps2_clk_low), .key_ack(key_ack), .ack_mode(ack_mode),
		.exp_valid(exp_valid), .exp_kind(exp_kind), .exp_value(exp_value),
		.run_done(run_done), .mismatch_count(mismatch_count), .fault_count(fault_count));

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;	// 100 ns period
	end

	// --------------------------------------------------
	// device model and record player
	// --------------------------------------------------
	task automatic wait_released();
		@(negedge clk);
		while (ps2_clk_low)
			@(negedge clk);	// keyboard may not send while inhibited
	endtask

	task automatic send_byte(input logic [7:0] code);
		logic [10:0] frame;
		frame = {1'b1, ~^code, code, 1'b0};	// stop, odd parity, data, start
		wait_released();
		for (int i = 0; i < ps2kbd_pkg::PS2_FRAME_BITS; i++)
		begin
			@(posedge clk);
			ps2_dat <= frame[i];	// lsb first
			repeat (HALF_BIT) @(posedge clk);
			ps2_clk <= 1'b0;	// host samples on this edge
			repeat (HALF_BIT) @(posedge clk);
			ps2_clk <= 1'b1;
		end
		@(posedge clk);
		ps2_dat <= 1'b1;
		repeat (IDLE_GAP) @(posedge clk);
	endtask

	task automatic post_expect(input logic kind, input logic [7:0] value);
		@(posedge clk);
		exp_valid <= 1'b1;
		exp_kind  <= kind;
		exp_value <= value;
		@(posedge clk);
		exp_valid <= 1'b0;
	endtask

	task automatic run_record(input logic [11:0] rec);
		case (rec[11:8])
			4'h1: send_byte(rec[7:0]);
			4'h2:
			begin
				wait_released();	// change mode between holds only
				@(posedge clk);
				ack_mode <= rec[0];
			end
			4'h3: post_expect(1'b0, rec[7:0]);	// key code
			4'h4: post_expect(1'b1, rec[7:0]);	// chord level
			default:
			begin
				$display("ERROR: unknown golden record %h", rec);
				script_errors = script_errors + 1;
			end
		endcase
	endtask

	initial
	begin
		reset     <= 1'b1;
		ps2_clk   <= 1'b1;	// lines idle high
		ps2_dat   <= 1'b1;
		ack_mode  <= 1'b1;
		exp_valid <= 1'b0;
		exp_kind  <= 1'b0;
		exp_value <= 8'h00;
		run_done  <= 1'b0;
		script_errors = 0;
		$readmemh("verif/ps2_keyboard_golden.txt", script);
		n_records = 0;
		n_send    = 0;
		n_key     = 0;
		while (n_records < SCRIPT_SIZE && !$isunknown(script[n_records]) &&
			script[n_records][11:8] != 4'h0)
		begin
			if (script[n_records][11:8] == 4'h1)
				n_send = n_send + 1;
			if (script[n_records][11:8] == 4'h3)
				n_key = n_key + 1;	// each key event may hold
			n_records = n_records + 1;
		end
		timeout_limit = n_send * FRAME_COST + n_key * HOLD_COST + 1000;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);
		for (idx = 0; idx < n_records; idx++)
			run_record(script[idx]);
		wait_released();
		@(posedge clk);
		run_done <= 1'b1;
		repeat (3) @(posedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count,
			fault_count + script_errors);
		if (mismatch_count == 0 && fault_count == 0 && script_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// --------------------------------------------------
	// host acknowledge and run limit
	// --------------------------------------------------
	initial
	begin
		key_ack <= 1'b0;
		forever
		begin
			@(negedge clk);
			if (key_strobe && ack_mode)
			begin
				repeat (4) @(posedge clk);	// host reacts a little later
				key_ack <= 1'b1;
				@(posedge clk);
				key_ack <= 1'b0;
			end
		end
	end

	initial
	begin
		cycle_count = 0;
		@(posedge clk);
		while (cycle_count <= timeout_limit)
		begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
		end
		$display("ERROR: run did not finish within %0d cycles", timeout_limit);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count,
			fault_count + script_errors + 1);
		$display("Test failed");
		$finish;
	end

endmodule
